//--- source/hdc_dim_pkg.sv
`default_nettype none

package hdc_dim_pkg;

    // hypervector width in bits
    // kept small so simulation stays quick
    localparam int HV_DIM = 64;

    // parallel encoder cores feeding the bundler
    localparam int CORE_NUM = 2;

    // vote counter width, two's complement
    localparam int CNT_W = 8;

    // saturation limits of the vote counter
    localparam int CNT_MAX = 2 ** (CNT_W - 1) - 1;
    localparam int CNT_MIN = -(2 ** (CNT_W - 1));

    // internal sum width, room for count plus all votes of one cycle
    localparam int SUM_W = CNT_W + 2;

    // input symbol width per core
    localparam int SYM_W = 4;

    // position counter width, covers 0 .. HV_DIM-1
    localparam int POS_W = 6;

endpackage

`default_nettype wire

//--- source/hdc_item_pkg.sv
`default_nettype none

package hdc_item_pkg;

    import hdc_dim_pkg::*;

    // seed for item vectors
    // each symbol value picks its own rotation of this word
    localparam logic [HV_DIM-1:0] BASE_HV = 64'h9e37_79b9_7f4a_7c15;

    // seed for position vectors
    // rotated by the running position of a core
    localparam logic [HV_DIM-1:0] POS_HV = 64'hc2b2_ae3d_27d4_eb4f;

    // rotation step per symbol value
    // item rotation is symbol * SYM_STRIDE, modulo HV_DIM
    localparam int SYM_STRIDE = 5;

    // left rotation of a hypervector
    // amt of 0 returns vec unchanged, the right shift then drops all bits
    function automatic logic [HV_DIM-1:0] rotl(
        input logic [HV_DIM-1:0] vec,
        input logic [POS_W-1:0]  amt
    );
        logic [HV_DIM-1:0] hi_part;
        logic [HV_DIM-1:0] lo_part;
        begin
            // bits moving up
            hi_part = vec << amt;
            // bits wrapping around from the top
            lo_part = vec >> (HV_DIM - int'(amt));
            return hi_part | lo_part;
        end
    endfunction

endpackage

`default_nettype wire

//--- source/hv_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module hv_encoder
    import hdc_dim_pkg::*;
    import hdc_item_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               clear,
    input  wire               symbol_v,
    input  wire  [SYM_W-1:0]  symbol,
    output logic [HV_DIM-1:0] core_hv,
    output logic              store
);

    // running position of this core
    logic [POS_W-1:0] pos;

    // rotation amount for the item vector
    logic [POS_W-1:0] item_rot;

    // item and position vectors for the current strobe
    logic [HV_DIM-1:0] item_hv;
    logic [HV_DIM-1:0] pos_hv;

    // bound vector, combinational
    logic [HV_DIM-1:0] bound_hv;

    // symbol * stride, wrapped onto the vector width
    assign item_rot = POS_W'((32'(symbol) * SYM_STRIDE) % HV_DIM);

    // item vector from the base seed
    assign item_hv = rotl(BASE_HV, item_rot);

    // position vector from the position seed
    // uses the position before this strobe advances it
    assign pos_hv = rotl(POS_HV, pos);

    // binding is a plain xor
    assign bound_hv = item_hv ^ pos_hv;

    // position counter
    // one step per accepted strobe, wraps at HV_DIM
    // clear wins over a strobe in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            pos <= '0;
        end else if (symbol_v) begin
            if (pos == POS_W'(HV_DIM - 1)) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

    // store pulse, one cycle per strobe
    // back-to-back strobes give back-to-back pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            store <= 1'b0;
        end else begin
            store <= symbol_v;
        end
    end

    // bound vector register
    // only meaningful while store is high
    always_ff @(posedge clk) begin
        if (symbol_v) begin
            core_hv <= bound_hv;
        end
    end

endmodule

`default_nettype wire

//--- source/bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_counter
    import hdc_dim_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                clear,
    input  wire  [CORE_NUM-1:0] core_result,
    input  wire  [CORE_NUM-1:0] store,
    output logic               sign_bit
);

    // running vote count for this bit
    logic signed [CNT_W-1:0] count;

    // votes of this cycle, count base and their sum
    logic signed [SUM_W-1:0] vote_sum;
    logic signed [SUM_W-1:0] count_base;
    logic signed [SUM_W-1:0] count_sum;

    // +1 for a one, -1 for a zero, nothing without store
    always_comb begin
        vote_sum = '0;
        for (int c = 0; c < CORE_NUM; c++) begin
            if (store[c]) begin
                if (core_result[c]) begin
                    vote_sum = vote_sum + SUM_W'(1);
                end else begin
                    vote_sum = vote_sum - SUM_W'(1);
                end
            end
        end
    end

    // clear drops the old count but keeps this cycle's votes
    assign count_base = clear ? '0 : SUM_W'(count);
    assign count_sum  = count_base + vote_sum;

    // saturate at the signed limits
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (count_sum > SUM_W'(CNT_MAX)) begin
            count <= CNT_W'(CNT_MAX);
        end else if (count_sum < SUM_W'(CNT_MIN)) begin
            count <= CNT_W'(CNT_MIN);
        end else begin
            count <= count_sum[CNT_W-1:0];
        end
    end

    // majority bit, strictly positive only
    // a tie reads as 0
    assign sign_bit = !count[CNT_W-1] && (count != '0);

endmodule

`default_nettype wire

//--- source/bundle_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_ctrl
    import hdc_dim_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clear,
    // core c owns slice c of the flat word
    input  wire  [CORE_NUM*HV_DIM-1:0]  core_hv,
    input  wire  [CORE_NUM-1:0]         store,
    input  wire                         stream_v,
    output logic [HV_DIM-1:0]           stream_d,
    output logic                        dout_v
);

    // majority vector, one bit per counter
    logic [HV_DIM-1:0] sign_vec;

    // one counter per hypervector bit
    for (genvar i = 0; i < HV_DIM; i++) begin : g_bit

        // bit i of every core, core 0 in the lsb
        logic [CORE_NUM-1:0] bit_slice;

        for (genvar c = 0; c < CORE_NUM; c++) begin : g_core
            assign bit_slice[c] = core_hv[c*HV_DIM + i];
        end

        bit_counter u_cnt (
            .clk         (clk),
            .rst         (rst),
            .clear       (clear),
            .core_result (bit_slice),
            .store       (store),
            .sign_bit    (sign_vec[i])
        );
    end

    // capture the sign vector on stream_v
    // stores counted at this same edge are not yet in sign_vec
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_d <= '0;
        end else if (stream_v) begin
            stream_d <= sign_vec;
        end
    end

    // output strobe, the cycle after stream_v
    always_ff @(posedge clk) begin
        if (rst) begin
            dout_v <= 1'b0;
        end else begin
            dout_v <= stream_v;
        end
    end

endmodule

`default_nettype wire

//--- source/hdc_bundler_top.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_top
    import hdc_dim_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clear,
    // one strobe per core
    input  wire  [CORE_NUM-1:0]         symbol_v,
    // core c owns symbol[c*SYM_W +: SYM_W]
    input  wire  [CORE_NUM*SYM_W-1:0]   symbol,
    input  wire                         stream_v,
    output logic [HV_DIM-1:0]           stream_d,
    output logic                        dout_v
);

    // bound vectors of all cores, flat
    logic [CORE_NUM*HV_DIM-1:0] core_hv;

    // store pulses, one per core
    logic [CORE_NUM-1:0] store;

    // encoder cores
    // first stage, one register from strobe to store
    for (genvar c = 0; c < CORE_NUM; c++) begin : g_enc
        hv_encoder u_enc (
            .clk      (clk),
            .rst      (rst),
            .clear    (clear),
            .symbol_v (symbol_v[c]),
            .symbol   (symbol[c*SYM_W +: SYM_W]),
            .core_hv  (core_hv[c*HV_DIM +: HV_DIM]),
            .store    (store[c])
        );
    end

    // bundler
    // second stage, counters plus the output register
    // a strobe at edge N shows in a capture at edge N+2 or later
    bundle_ctrl u_bundle (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .core_hv  (core_hv),
        .store    (store),
        .stream_v (stream_v),
        .stream_d (stream_d),
        .dout_v   (dout_v)
    );

endmodule

`default_nettype wire

//--- dv/tb_hdc_bundler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hdc_bundler
    import hdc_dim_pkg::*;
    import hdc_item_pkg::*;
;

    // cycles allowed between stream_v and dout_v
    localparam int DOUT_TIMEOUT = 8;

    // random rows after the directed part
    localparam int RAND_ROWS = 200;

    // one stimulus row, applied for one clock cycle
    typedef struct packed {
        logic                      clr;
        logic [CORE_NUM-1:0]       sv;
        logic [CORE_NUM*SYM_W-1:0] sym;
        logic                      strm;
        logic                      save_ref;
        logic                      cmp_ref;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic                      clear;
    logic [CORE_NUM-1:0]       symbol_v;
    logic [CORE_NUM*SYM_W-1:0] symbol;
    logic                      stream_v;
    logic [HV_DIM-1:0]         stream_d;
    logic                      dout_v;

    row_t tbl[$];

    // reference model state
    int                cnt [HV_DIM];
    int                pos [CORE_NUM];
    logic [HV_DIM-1:0] pend_hv [CORE_NUM];
    logic [CORE_NUM-1:0] pend_v;
    logic [HV_DIM-1:0] exp_stream;

    // model capture after reset, expected again after the clear
    logic [HV_DIM-1:0] ref_hv;

    logic [31:0] rng_state;
    int          cur_row;
    int          value_errs;
    int          timing_errs;

    hdc_bundler_top UUT (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .symbol_v (symbol_v),
        .symbol   (symbol),
        .stream_v (stream_v),
        .stream_d (stream_d),
        .dout_v   (dout_v)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 32-bit xorshift, shifts 13 17 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // bit i moves to bit (i + amt) mod HV_DIM
    function automatic logic [HV_DIM-1:0] rot_left(input logic [HV_DIM-1:0] vec, input int amt);
        logic [HV_DIM-1:0] r;
        r = '0;
        for (int i = 0; i < HV_DIM; i++) begin
            r[(i + amt) % HV_DIM] = vec[i];
        end
        return r;
    endfunction

    // item vector xor position vector
    function automatic logic [HV_DIM-1:0] bind_vec(input logic [SYM_W-1:0] s, input int p);
        logic [HV_DIM-1:0] item;
        logic [HV_DIM-1:0] posv;
        item = rot_left(BASE_HV, (int'(s) * SYM_STRIDE) % HV_DIM);
        posv = rot_left(POS_HV, p);
        return item ^ posv;
    endfunction

    // symbol whose bound vector has bit 0 equal to want at position p
    function automatic int pick_sym(input int p, input logic want);
        logic [HV_DIM-1:0] hv;
        int pick;
        pick = 0;
        for (int s = (1 << SYM_W) - 1; s >= 0; s--) begin
            hv = bind_vec(SYM_W'(s), p);
            if (hv[0] == want) begin
                pick = s;
            end
        end
        return pick;
    endfunction

    // core 0 in the low slice
    function automatic logic [CORE_NUM*SYM_W-1:0] pack_sym(input int s0, input int s1);
        logic [CORE_NUM*SYM_W-1:0] w;
        w = '0;
        w[0 +: SYM_W] = SYM_W'(s0);
        w[SYM_W +: SYM_W] = SYM_W'(s1);
        return w;
    endfunction

    function automatic row_t make_row(
        input logic                      clr,
        input logic [CORE_NUM-1:0]       sv,
        input logic [CORE_NUM*SYM_W-1:0] sym,
        input logic                      strm
    );
        row_t r;
        r = '0;
        r.clr  = clr;
        r.sv   = sv;
        r.sym  = sym;
        r.strm = strm;
        return r;
    endfunction

    task automatic check_hv(input string name, input logic [HV_DIM-1:0] act,
                            input logic [HV_DIM-1:0] exp);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s row %0d: got %h expected %h", name, cur_row, act, exp);
        end
    endtask

    task automatic check_pulse(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            value_errs++;
            $display("FAIL %s row %0d: got %h expected %h", name, cur_row, act, exp);
        end
    endtask

    task automatic drive_row(input row_t r);
        clear    = r.clr;
        symbol_v = r.sv;
        symbol   = r.sym;
        stream_v = r.strm;
    endtask

    task automatic model_reset();
        for (int i = 0; i < HV_DIM; i++) begin
            cnt[i] = 0;
        end
        for (int c = 0; c < CORE_NUM; c++) begin
            pos[c]     = 0;
            pend_hv[c] = '0;
        end
        pend_v     = '0;
        exp_stream = '0;
    endtask

    // one rising edge of the model, in the order the hardware sees it
    task automatic model_step(input row_t r);
        int sum;
        // capture uses counts from before this edge
        if (r.strm) begin
            for (int i = 0; i < HV_DIM; i++) begin
                exp_stream[i] = (cnt[i] > 0);
            end
        end
        // stores in flight still vote after a clear
        for (int i = 0; i < HV_DIM; i++) begin
            sum = r.clr ? 0 : cnt[i];
            for (int c = 0; c < CORE_NUM; c++) begin
                if (pend_v[c]) begin
                    sum += pend_hv[c][i] ? 1 : -1;
                end
            end
            if (sum > CNT_MAX) begin
                sum = CNT_MAX;
            end
            if (sum < CNT_MIN) begin
                sum = CNT_MIN;
            end
            cnt[i] = sum;
        end
        // encoders bind with the old position
        for (int c = 0; c < CORE_NUM; c++) begin
            pend_v[c] = r.sv[c];
            if (r.sv[c]) begin
                pend_hv[c] = bind_vec(r.sym[c*SYM_W +: SYM_W], pos[c]);
            end
            if (r.clr) begin
                pos[c] = 0;
            end else if (r.sv[c]) begin
                pos[c] = (pos[c] + 1) % HV_DIM;
            end
        end
    endtask

    task automatic build_table();
        row_t r;
        logic [31:0] x;
        int ps;
        // stream with nothing stored
        tbl.push_back(make_row(1'b0, '0, '0, 1'b1));
        // single symbol on core 0 at position 0
        tbl.push_back(make_row(1'b0, 2'b01, pack_sym(3, 0), 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        r = make_row(1'b0, '0, '0, 1'b1);
        r.save_ref = 1'b1;
        tbl.push_back(r);
        // same symbol three times, positions 0 1 2
        tbl.push_back(make_row(1'b1, '0, '0, 1'b0));
        for (int k = 0; k < 3; k++) begin
            tbl.push_back(make_row(1'b0, 2'b01, pack_sym(7, 0), 1'b0));
        end
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b1));
        // both cores in one cycle, differing bits tie
        tbl.push_back(make_row(1'b1, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, 2'b11, pack_sym(2, 9), 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b1));
        // clear, then the post-reset sequence again
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b1, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, 2'b01, pack_sym(3, 0), 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        r = make_row(1'b0, '0, '0, 1'b1);
        r.cmp_ref = 1'b1;
        tbl.push_back(r);
        // long run of equal votes on bit 0
        // up to the positive limit, down past the negative one, then back up
        tbl.push_back(make_row(1'b1, '0, '0, 1'b0));
        for (int k = 0; k < 340; k++) begin
            ps = pick_sym(k % HV_DIM, (k < 100 || k >= 260) ? 1'b1 : 1'b0);
            tbl.push_back(make_row(1'b0, 2'b11, pack_sym(ps, ps), (k % 16) == 15));
        end
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b1));
        // random rows, rare clears and frequent streams
        x = rng_state;
        for (int k = 0; k < RAND_ROWS; k++) begin
            x = xorshift32(x);
            tbl.push_back(make_row(x[7:0] < 8'd8, x[9:8], x[17:10], x[20:18] < 3'd3));
        end
        rng_state = x;
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b0));
        tbl.push_back(make_row(1'b0, '0, '0, 1'b1));
    endtask

    // called on the falling edge after a stream row
    task automatic wait_and_check(input row_t r);
        int waited;
        row_t idle;
        waited = 0;
        idle = make_row(1'b0, '0, '0, 1'b0);
        while (dout_v !== 1'b1 && waited < DOUT_TIMEOUT) begin
            drive_row(idle);
            model_step(idle);
            @(negedge clk);
            waited++;
        end
        if (dout_v !== 1'b1) begin
            timing_errs++;
            $display("dout_v never rose after stream_v at row %0d", cur_row);
        end else begin
            if (waited != 0) begin
                timing_errs++;
                $display("dout_v came %0d cycles late at row %0d", waited, cur_row);
            end
            check_hv("stream_d", stream_d, exp_stream);
            if (r.save_ref) begin
                ref_hv = exp_stream;
            end
            if (r.cmp_ref) begin
                check_hv("stream_d", stream_d, ref_hv);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        clear       = 1'b0;
        symbol_v    = '0;
        symbol      = '0;
        stream_v    = 1'b0;
        rng_state   = 32'd85;
        ref_hv      = '0;
        cur_row     = -1;
        value_errs  = 0;
        timing_errs = 0;
        build_table();
        model_reset();
        // four rising edges in reset, release on the falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle outputs straight after reset
        check_hv("stream_d", stream_d, '0);
        check_pulse("dout_v", dout_v, 1'b0);
        for (int idx = 0; idx < tbl.size(); idx++) begin
            cur_row = idx;
            drive_row(tbl[idx]);
            model_step(tbl[idx]);
            @(negedge clk);
            if (tbl[idx].strm) begin
                wait_and_check(tbl[idx]);
            end else begin
                // dout_v only follows a stream row
                check_pulse("dout_v", dout_v, 1'b0);
            end
        end
        drive_row(make_row(1'b0, '0, '0, 1'b0));
        @(negedge clk);
        $display("errors: %0d value, %0d timing", value_errs, timing_errs);
        if (value_errs == 0 && timing_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
source/hdc_dim_pkg.sv
source/hdc_item_pkg.sv
source/hv_encoder.sv
source/bit_counter.sv
source/bundle_ctrl.sv
source/hdc_bundler_top.sv
dv/tb_hdc_bundler.sv

//--- Makefile
# Verilator build of the HDC bundler testbench

TOP := tb_hdc_bundler
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# the pass message in the log decides the result
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
